// File: alu_mdu_iq.f
hdl/iq_pkg.sv
hdl/iq_dispatch_alloc.sv
hdl/iq_entry_array.sv
hdl/iq_issue_select.sv
hdl/alu_mdu_iq.sv
verif/alu_mdu_iq_assert.sv
verif/alu_mdu_iq_tb.sv

// File: hdl/alu_mdu_iq.sv
/*
    ALU / MDU issue queue
    age-ordered queue fed by up to four dispatch ways per cycle, issuing
    the oldest ready op to each of the ALU and MDU pipelines
*/

`timescale 1ns/1ps

module alu_mdu_iq
    import iq_pkg::*;
#(
    parameter int IQ_ENTRIES    = 8,
    parameter int DISPATCH_WAYS = 4
) (
    input  logic                             CLK,
    input  logic                             nRST,

    // dispatch
    input  iq_dispatch_t [DISPATCH_WAYS-1:0] dispatch_by_way,
    output logic         [DISPATCH_WAYS-1:0] dispatch_ack_by_way,

    // pipeline levels
    input  logic                             alu_pipeline_ready,
    input  logic                             mdu_pipeline_ready,

    // writeback
    input  wb_bank_t     [BANK_COUNT-1:0]    wb_bus_by_bank,

    // issue
    output iq_issue_t                        issue_alu,
    output iq_issue_t                        issue_mdu
);

    iq_entry_t [IQ_ENTRIES-1:0] entries;
    iq_entry_t [IQ_ENTRIES-1:0] dispatch_by_entry;
    logic      [IQ_ENTRIES-1:0] a_forward_by_entry;
    logic      [IQ_ENTRIES-1:0] b_forward_by_entry;
    logic      [IQ_ENTRIES-1:0] alu_valid_by_entry;
    logic      [IQ_ENTRIES-1:0] mdu_valid_by_entry;
    logic      [IQ_ENTRIES-1:0] alu_collapse_mask;
    logic      [IQ_ENTRIES-1:0] mdu_collapse_mask;

    // class bits per pipeline
    for (genvar i = 0; i < IQ_ENTRIES; i++) begin : g_class
        assign alu_valid_by_entry[i] = entries[i].is_alu;
        assign mdu_valid_by_entry[i] = entries[i].is_mdu;
    end

    // ---------------------------------------------------------
    // dispatch side

    iq_dispatch_alloc #(
        .IQ_ENTRIES    (IQ_ENTRIES),
        .DISPATCH_WAYS (DISPATCH_WAYS)
    ) i_dispatch_alloc (
        .entries             (entries),
        .dispatch_by_way     (dispatch_by_way),
        .dispatch_ack_by_way (dispatch_ack_by_way),
        .dispatch_by_entry   (dispatch_by_entry)
    );

    iq_entry_array #(
        .IQ_ENTRIES (IQ_ENTRIES)
    ) i_entry_array (
        .CLK                (CLK),
        .nRST               (nRST),
        .dispatch_by_entry  (dispatch_by_entry),
        .wb_bus_by_bank     (wb_bus_by_bank),
        .alu_collapse_mask  (alu_collapse_mask),
        .mdu_collapse_mask  (mdu_collapse_mask),
        .entries            (entries),
        .a_forward_by_entry (a_forward_by_entry),
        .b_forward_by_entry (b_forward_by_entry)
    );

    // ---------------------------------------------------------
    // issue side

    iq_issue_select #(
        .IQ_ENTRIES (IQ_ENTRIES)
    ) i_issue_alu (
        .entries              (entries),
        .class_valid_by_entry (alu_valid_by_entry),
        .a_forward_by_entry   (a_forward_by_entry),
        .b_forward_by_entry   (b_forward_by_entry),
        .pipeline_ready       (alu_pipeline_ready),
        .issue                (issue_alu),
        .collapse_mask        (alu_collapse_mask)
    );

    iq_issue_select #(
        .IQ_ENTRIES (IQ_ENTRIES)
    ) i_issue_mdu (
        .entries              (entries),
        .class_valid_by_entry (mdu_valid_by_entry),
        .a_forward_by_entry   (a_forward_by_entry),
        .b_forward_by_entry   (b_forward_by_entry),
        .pipeline_ready       (mdu_pipeline_ready),
        .issue                (issue_mdu),
        .collapse_mask        (mdu_collapse_mask)
    );

endmodule

// File: hdl/iq_dispatch_alloc.sv
/*
    Dispatch allocation
    each way in turn takes the lowest free entry left by the ways below it,
    gets an ack when it found one, and its op is routed to that entry
*/

`timescale 1ns/1ps

module iq_dispatch_alloc
    import iq_pkg::*;
#(
    parameter int IQ_ENTRIES    = 8,
    parameter int DISPATCH_WAYS = 4
) (
    input  iq_entry_t    [IQ_ENTRIES-1:0]    entries,
    input  iq_dispatch_t [DISPATCH_WAYS-1:0] dispatch_by_way,
    output logic         [DISPATCH_WAYS-1:0] dispatch_ack_by_way,
    output iq_entry_t    [IQ_ENTRIES-1:0]    dispatch_by_entry
);

    // free entries at the start of the cycle
    logic [IQ_ENTRIES-1:0] free_by_entry;

    // entry picked by each way, one-hot or zero
    logic [DISPATCH_WAYS-1:0][IQ_ENTRIES-1:0] pick_by_way;

    always_comb begin
        for (int e = 0; e < IQ_ENTRIES; e++) begin
            free_by_entry[e] = ~(entries[e].is_alu | entries[e].is_mdu);
        end
    end

    // ---------------------------------------------------------
    // cascaded lowest-free pick

    always_comb begin
        logic [IQ_ENTRIES-1:0] open;
        logic                  found;

        open = free_by_entry;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            pick_by_way[w] = '0;
            found = 1'b0;
            for (int e = 0; e < IQ_ENTRIES; e++) begin
                if (dispatch_by_way[w].attempt && open[e] && !found) begin
                    pick_by_way[w][e] = 1'b1;
                    found = 1'b1;
                end
            end
            // idle ways leave the open set untouched
            open = open & ~pick_by_way[w];
        end
    end

    always_comb begin
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            dispatch_ack_by_way[w] = |pick_by_way[w];
        end
    end

    // ---------------------------------------------------------
    // way to entry routing

    always_comb begin
        dispatch_by_entry = '0;
        for (int e = 0; e < IQ_ENTRIES; e++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                if (pick_by_way[w][e]) begin
                    dispatch_by_entry[e].is_alu  = dispatch_by_way[w].is_alu;
                    dispatch_by_entry[e].is_mdu  = dispatch_by_way[w].is_mdu;
                    dispatch_by_entry[e].payload = dispatch_by_way[w].payload;
                end
            end
        end
    end

endmodule

// File: hdl/iq_entry_array.sv
/*
    Issue queue entry array
    age-ordered entry registers, writeback wakeup compare, and compaction
    by zero, one or two places after the two issue ports take their ops
*/

`timescale 1ns/1ps

module iq_entry_array
    import iq_pkg::*;
#(
    parameter int IQ_ENTRIES = 8
) (
    input  logic                         CLK,
    input  logic                         nRST,

    input  iq_entry_t [IQ_ENTRIES-1:0]   dispatch_by_entry,
    input  wb_bank_t  [BANK_COUNT-1:0]   wb_bus_by_bank,

    input  logic      [IQ_ENTRIES-1:0]   alu_collapse_mask,
    input  logic      [IQ_ENTRIES-1:0]   mdu_collapse_mask,

    output iq_entry_t [IQ_ENTRIES-1:0]   entries,
    output logic      [IQ_ENTRIES-1:0]   a_forward_by_entry,
    output logic      [IQ_ENTRIES-1:0]   b_forward_by_entry
);

    // class bits and payload per entry
    logic   [IQ_ENTRIES-1:0] alu_q;
    logic   [IQ_ENTRIES-1:0] mdu_q;
    iq_op_t [IQ_ENTRIES-1:0] payload_q;

    // suffix masks extended one place past the top
    logic [IQ_ENTRIES:0] alu_mask_ext;
    logic [IQ_ENTRIES:0] mdu_mask_ext;

    // what each position offers to the entries below it
    iq_entry_t cand [IQ_ENTRIES+2];
    iq_entry_t nxt  [IQ_ENTRIES];

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            entries[i].is_alu  = alu_q[i];
            entries[i].is_mdu  = mdu_q[i];
            entries[i].payload = payload_q[i];
        end
    end

    // ---------------------------------------------------------
    // wakeup against the writeback bus

    always_comb begin
        logic [BANK_W-1:0] a_bank;
        logic [BANK_W-1:0] b_bank;

        for (int i = 0; i < IQ_ENTRIES; i++) begin
            a_bank = payload_q[i].a_pr[BANK_W-1:0];
            b_bank = payload_q[i].b_pr[BANK_W-1:0];
            a_forward_by_entry[i] = wb_bus_by_bank[a_bank].valid
                & (wb_bus_by_bank[a_bank].upper_pr == payload_q[i].a_pr[PR_W-1:BANK_W]);
            b_forward_by_entry[i] = wb_bus_by_bank[b_bank].valid
                & (wb_bus_by_bank[b_bank].upper_pr == payload_q[i].b_pr[PR_W-1:BANK_W]);
        end
    end

    // ---------------------------------------------------------
    // compaction

    assign alu_mask_ext = {alu_collapse_mask[IQ_ENTRIES-1], alu_collapse_mask};
    assign mdu_mask_ext = {mdu_collapse_mask[IQ_ENTRIES-1], mdu_collapse_mask};

    // held op with wakeup folded in or the dispatch routed here
    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (alu_q[i] | mdu_q[i]) begin
                cand[i] = entries[i];
                cand[i].payload.a_ready = payload_q[i].a_ready | a_forward_by_entry[i];
                cand[i].payload.b_ready = payload_q[i].b_ready | b_forward_by_entry[i];
            end
            else begin
                cand[i] = dispatch_by_entry[i];
            end
        end
        // nothing lives above the top
        cand[IQ_ENTRIES]   = '0;
        cand[IQ_ENTRIES+1] = '0;
    end

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            // both issued ops sit at or below i+1
            if ((alu_mask_ext[i] & mdu_mask_ext[i+1]) | (alu_mask_ext[i+1] & mdu_mask_ext[i])) begin
                nxt[i] = cand[i+2];
            end
            else if (alu_mask_ext[i] | mdu_mask_ext[i]) begin
                nxt[i] = cand[i+1];
            end
            else begin
                nxt[i] = cand[i];
            end
        end
    end

    // ---------------------------------------------------------
    // registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            alu_q <= '0;
            mdu_q <= '0;
        end
        else begin
            for (int i = 0; i < IQ_ENTRIES; i++) begin
                alu_q[i] <= nxt[i].is_alu;
                mdu_q[i] <= nxt[i].is_mdu;
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            payload_q[i] <= nxt[i].payload;
        end
    end

endmodule

// File: hdl/iq_issue_select.sv
/*
    Issue select for one pipeline
    oldest ready entry of the class wins, its payload and forward flags go
    out on the issue port, and the collapse mask covers it and all above
*/

`timescale 1ns/1ps

module iq_issue_select
    import iq_pkg::*;
#(
    parameter int IQ_ENTRIES = 8
) (
    input  iq_entry_t [IQ_ENTRIES-1:0] entries,
    input  logic      [IQ_ENTRIES-1:0] class_valid_by_entry,
    input  logic      [IQ_ENTRIES-1:0] a_forward_by_entry,
    input  logic      [IQ_ENTRIES-1:0] b_forward_by_entry,
    input  logic                       pipeline_ready,

    output iq_issue_t                  issue,
    output logic      [IQ_ENTRIES-1:0] collapse_mask
);

    logic [IQ_ENTRIES-1:0] ready_by_entry;
    logic [IQ_ENTRIES-1:0] one_hot_by_entry;

    // ---------------------------------------------------------
    // ready check

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            ready_by_entry[i] = pipeline_ready
                & class_valid_by_entry[i]
                & (entries[i].payload.a_ready | a_forward_by_entry[i])
                & (entries[i].payload.b_ready | b_forward_by_entry[i]);
        end
    end

    // lowest set bit is the oldest
    assign one_hot_by_entry = ready_by_entry & (~ready_by_entry + 1'b1);

    // zero when nothing issues
    assign collapse_mask = ~(one_hot_by_entry - 1'b1);

    // ---------------------------------------------------------
    // one-hot payload mux

    always_comb begin
        issue = '0;
        issue.valid = |ready_by_entry;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (one_hot_by_entry[i]) begin
                issue.op        = entries[i].payload.op;
                issue.a_pr      = entries[i].payload.a_pr;
                issue.a_forward = a_forward_by_entry[i];
                issue.b_pr      = entries[i].payload.b_pr;
                issue.b_forward = b_forward_by_entry[i];
                issue.dest_pr   = entries[i].payload.dest_pr;
                issue.rob_index = entries[i].payload.rob_index;
            end
        end
    end

endmodule

// File: hdl/iq_pkg.sv
/*
    Issue queue package
    widths and packed structs shared by the ALU/MDU issue queue
*/

package iq_pkg;

    // ---------------------------------------------------------
    // widths
    localparam int PR_W       = 7;
    localparam int ROB_W      = 7;
    localparam int BANK_W     = 2;
    localparam int BANK_COUNT = 4;
    localparam int OP_W       = 4;

    // ---------------------------------------------------------
    // op payload as it sits in the queue
    typedef struct packed {
        logic [OP_W-1:0]  op;
        logic [PR_W-1:0]  a_pr;
        logic             a_ready;
        logic [PR_W-1:0]  b_pr;
        logic             b_ready;
        logic [PR_W-1:0]  dest_pr;
        logic [ROB_W-1:0] rob_index;
    } iq_op_t;

    // one dispatch way
    typedef struct packed {
        logic   attempt;
        logic   is_alu;
        logic   is_mdu;
        iq_op_t payload;
    } iq_dispatch_t;

    // one queue entry, empty when neither class bit is set
    typedef struct packed {
        logic   is_alu;
        logic   is_mdu;
        iq_op_t payload;
    } iq_entry_t;

    // writeback bus, one per register file bank
    typedef struct packed {
        logic                   valid;
        logic [PR_W-BANK_W-1:0] upper_pr;
    } wb_bank_t;

    // issue port toward a pipeline
    typedef struct packed {
        logic             valid;
        logic [OP_W-1:0]  op;
        logic [PR_W-1:0]  a_pr;
        logic             a_forward;
        logic [PR_W-1:0]  b_pr;
        logic             b_forward;
        logic [PR_W-1:0]  dest_pr;
        logic [ROB_W-1:0] rob_index;
    } iq_issue_t;

endpackage

// File: verif/alu_mdu_iq_assert.sv
/*
    Issue queue assertions
    bound to the top level, covers issue against pipeline ready, ack order
    across the dispatch ways, and a quiet queue in reset
*/

`timescale 1ns/1ps

module alu_mdu_iq_assert
    import iq_pkg::*;
#(
    parameter int DISPATCH_WAYS = 4
) (
    input logic                             CLK,
    input logic                             nRST,
    input iq_dispatch_t [DISPATCH_WAYS-1:0] dispatch_by_way,
    input logic         [DISPATCH_WAYS-1:0] dispatch_ack_by_way,
    input logic                             alu_pipeline_ready,
    input logic                             mdu_pipeline_ready,
    input iq_issue_t                        issue_alu,
    input iq_issue_t                        issue_mdu
);

    int unsigned issue_fail_count;
    int unsigned ack_fail_count;
    int unsigned reset_fail_count;

    logic ack_prefix;

    // acked ways are the lowest attempting ways
    always_comb begin
        logic unacked_below;

        unacked_below = 1'b0;
        ack_prefix    = 1'b1;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            if (dispatch_ack_by_way[w] && (unacked_below || !dispatch_by_way[w].attempt)) begin
                ack_prefix = 1'b0;
            end
            if (dispatch_by_way[w].attempt && !dispatch_ack_by_way[w]) begin
                unacked_below = 1'b1;
            end
        end
    end

    issue_needs_ready: assert property (@(posedge CLK) disable iff (!nRST)
        (alu_pipeline_ready || !issue_alu.valid) && (mdu_pipeline_ready || !issue_mdu.valid))
    else begin
        $error("issue valid while its pipeline is not ready");
        issue_fail_count++;
    end

    acks_in_way_order: assert property (@(posedge CLK) disable iff (!nRST) ack_prefix)
    else begin
        $error("acks are not a prefix of the attempting ways");
        ack_fail_count++;
    end

    quiet_in_reset: assert property (@(posedge CLK)
        !nRST |-> (dispatch_ack_by_way == '0 && !issue_alu.valid && !issue_mdu.valid))
    else begin
        $error("ack or issue while in reset");
        reset_fail_count++;
    end

endmodule

bind alu_mdu_iq alu_mdu_iq_assert #(.DISPATCH_WAYS(DISPATCH_WAYS)) i_assert (.*);

// File: verif/alu_mdu_iq_tb.sv
/*
    ALU / MDU issue queue testbench
    directed table then random rows, checked against an age-ordered queue model
*/

`timescale 1ns/1ps

module alu_mdu_iq_tb
    import iq_pkg::*;
();

    localparam int IQ_ENTRIES    = 8;
    localparam int DISPATCH_WAYS = 4;
    localparam int TABLE_ROWS    = 16;
    localparam int RANDOM_ROWS   = 200;
    localparam int DRAIN_LIMIT   = 64;

    logic                             CLK;
    logic                             nRST;
    iq_dispatch_t [DISPATCH_WAYS-1:0] dispatch_by_way;
    logic         [DISPATCH_WAYS-1:0] dispatch_ack_by_way;
    logic                             alu_pipeline_ready;
    logic                             mdu_pipeline_ready;
    wb_bank_t     [BANK_COUNT-1:0]    wb_bus_by_bank;
    iq_issue_t                        issue_alu;
    iq_issue_t                        issue_mdu;

    // stimulus table with ready levels as {alu, mdu}
    iq_dispatch_t [DISPATCH_WAYS-1:0] row_ways  [TABLE_ROWS];
    wb_bank_t     [BANK_COUNT-1:0]    row_wb    [TABLE_ROWS];
    logic         [1:0]               row_ready [TABLE_ROWS];
    logic         [DISPATCH_WAYS-1:0] row_ack   [TABLE_ROWS];

    // reference model with the oldest op at index 0
    iq_entry_t   model_q [IQ_ENTRIES];
    int          model_count;
    int          error_count;
    logic [31:0] rng_state;

    alu_mdu_iq #(.IQ_ENTRIES(IQ_ENTRIES), .DISPATCH_WAYS(DISPATCH_WAYS)) i_dut (.*);

    always #2 CLK = ~CLK;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic iq_dispatch_t make_op(input logic alu, input logic [OP_W-1:0] op,
        input logic [PR_W-1:0] a_pr, input logic a_ready, input logic [PR_W-1:0] b_pr,
        input logic b_ready, input logic [ROB_W-1:0] rob);
        return {1'b1, alu, ~alu, op, a_pr, a_ready, b_pr, b_ready, rob ^ 7'h40, rob};
    endfunction

    // bank picked by the low bits and upper bits compared
    function automatic logic writeback_hit(input logic [PR_W-1:0] pr);
        wb_bank_t bank;
        bank = wb_bus_by_bank[pr[BANK_W-1:0]];
        return bank.valid && (bank.upper_pr == pr[PR_W-1:BANK_W]);
    endfunction

    function automatic iq_issue_t predict_issue(input logic want_alu, input logic pipe_ready,
                                                output int slot);
        iq_issue_t result;
        iq_entry_t e;
        logic      a_fwd;
        logic      b_fwd;
        result = '0;
        slot   = -1;
        for (int i = 0; i < model_count; i++) begin
            e     = model_q[i];
            a_fwd = writeback_hit(e.payload.a_pr);
            b_fwd = writeback_hit(e.payload.b_pr);
            if (pipe_ready && slot < 0 && (want_alu ? e.is_alu : e.is_mdu)
                && (e.payload.a_ready || a_fwd) && (e.payload.b_ready || b_fwd)) begin
                slot   = i;
                result = {1'b1, e.payload.op, e.payload.a_pr, a_fwd, e.payload.b_pr, b_fwd,
                          e.payload.dest_pr, e.payload.rob_index};
            end
        end
        return result;
    endfunction

    task automatic compare_issue(input string port, input iq_issue_t got, input iq_issue_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("error %0t: %s issue %h, expected %h", $time, port, got, exp);
            error_count++;
        end
    endtask

    // ---------------------------------------------------------
    // one cycle of drive, check before the edge and model update

    task automatic run_cycle(input iq_dispatch_t [DISPATCH_WAYS-1:0] ways,
        input logic alu_ready, input logic mdu_ready, input wb_bank_t [BANK_COUNT-1:0] wb,
        input logic use_table, input logic [DISPATCH_WAYS-1:0] table_ack);
        iq_issue_t                exp_alu;
        iq_issue_t                exp_mdu;
        int                       alu_slot;
        int                       mdu_slot;
        int                       attempts;
        int                       kept_count;
        logic [DISPATCH_WAYS-1:0] exp_ack;
        iq_entry_t                kept [IQ_ENTRIES];

        @(posedge CLK);
        #0.5;
        dispatch_by_way    = ways;
        alu_pipeline_ready = alu_ready;
        mdu_pipeline_ready = mdu_ready;
        wb_bus_by_bank     = wb;
        #3;
        exp_alu  = predict_issue(1'b1, alu_ready, alu_slot);
        exp_mdu  = predict_issue(1'b0, mdu_ready, mdu_slot);
        attempts = 0;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            exp_ack[w] = ways[w].attempt && (IQ_ENTRIES - model_count > attempts);
            attempts += int'(ways[w].attempt);
        end
        compare_issue("alu", issue_alu, exp_alu);
        compare_issue("mdu", issue_mdu, exp_mdu);
        if (dispatch_ack_by_way !== exp_ack) begin
            $display("error %0t: acks %b, model expects %b", $time, dispatch_ack_by_way, exp_ack);
            error_count++;
        end
        if (use_table && dispatch_ack_by_way !== table_ack) begin
            $display("error %0t: acks %b, table expects %b", $time, dispatch_ack_by_way, table_ack);
            error_count++;
        end
        // held ops wake up, issued ops leave, acked ops join in way order
        kept_count = 0;
        for (int i = 0; i < model_count; i++) begin
            if (i != alu_slot && i != mdu_slot) begin
                kept[kept_count] = model_q[i];
                kept[kept_count].payload.a_ready |= writeback_hit(model_q[i].payload.a_pr);
                kept[kept_count].payload.b_ready |= writeback_hit(model_q[i].payload.b_pr);
                kept_count++;
            end
        end
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            if (exp_ack[w]) begin
                kept[kept_count] = {ways[w].is_alu, ways[w].is_mdu, ways[w].payload};
                kept_count++;
            end
        end
        model_q     = kept;
        model_count = kept_count;
    endtask

    // ---------------------------------------------------------
    // directed rows

    task automatic load_table();
        for (int n = 0; n < TABLE_ROWS; n++) begin
            row_ways[n]  = '0;
            row_wb[n]    = '0;
            row_ready[n] = 2'b11;
            row_ack[n]   = '0;
        end
        // four ALU then four MDU ops into an empty queue
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            row_ways[0][w] = make_op(1'b1, OP_W'(w), PR_W'(8 + w), 1'b1, PR_W'(16 + w), 1'b1,
                                     ROB_W'(w));
            row_ways[1][w] = make_op(1'b0, OP_W'(4 + w), PR_W'(24 + w), 1'b1, PR_W'(32 + w),
                                     1'b1, ROB_W'(4 + w));
        end
        // attempts at a full queue and then while ops leave
        for (int w = 0; w < 3; w++) begin
            row_ways[2][w] = make_op(1'b1, 4'd8, PR_W'(40 + w), 1'b1, 7'd3, 1'b1, ROB_W'(8 + w));
            row_ways[3][w] = row_ways[2][w];
            row_ways[4][w] = row_ways[2][w];
        end
        row_ack[0]   = 4'b1111;
        row_ack[1]   = 4'b1111;
        row_ack[4]   = 4'b0011;
        row_ready[1] = 2'b00;
        row_ready[2] = 2'b00;
        row_ready[4] = 2'b10;
        // mdu stalled while alu ops drain
        for (int n = 6; n <= 8; n++) begin
            row_ready[n] = 2'b10;
        end
        row_ready[9]  = 2'b01;
        row_ready[10] = 2'b01;
        // wakeup of pr 13 on bank 1 and pr 22 on bank 2
        row_ways[11][0] = make_op(1'b1, 4'd1, 7'd13, 1'b0, 7'd3, 1'b1, 7'd20);
        row_ways[11][1] = make_op(1'b0, 4'd2, 7'd5, 1'b1, 7'd22, 1'b0, 7'd21);
        row_ack[11]     = 4'b0011;
        row_ready[13]   = 2'b10;
        row_wb[13][1]   = {1'b1, 5'd3};
        row_wb[13][2]   = {1'b1, 5'd5};
    endtask

    initial begin
        iq_dispatch_t [DISPATCH_WAYS-1:0] ways;
        wb_bank_t     [BANK_COUNT-1:0]    wb;
        logic         [31:0]              r;
        iq_entry_t                        oldest;
        int                               waited;
        int                               assert_errors;

        CLK                = 1'b0;
        nRST               = 1'b0;
        dispatch_by_way    = '0;
        alu_pipeline_ready = 1'b0;
        mdu_pipeline_ready = 1'b0;
        wb_bus_by_bank     = '0;
        model_count        = 0;
        error_count        = 0;
        rng_state          = 32'd68745;
        load_table();
        repeat (16) @(posedge CLK);
        #0.5;
        nRST = 1'b1;

        for (int n = 0; n < TABLE_ROWS; n++) begin
            run_cycle(row_ways[n], row_ready[n][1], row_ready[n][0], row_wb[n], 1'b1, row_ack[n]);
        end

        // random rows over a small register range so writebacks hit
        for (int n = 0; n < RANDOM_ROWS; n++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                r       = next_random();
                ways[w] = make_op(r[0], r[5:2], {3'b0, r[9:6]}, r[10] | r[11],
                                  {3'b0, r[15:12]}, r[16] | r[17], r[24:18]);
                ways[w].attempt = r[1];
            end
            r = next_random();
            for (int b = 0; b < BANK_COUNT; b++) begin
                wb[b].valid    = r[4 + b];
                wb[b].upper_pr = {3'b0, r[8 + 2 * b +: 2]};
            end
            run_cycle(ways, r[0] | r[1], r[2] | r[3], wb, 1'b0, '0);
        end

        // drain by waking the oldest op's missing operands
        waited = 0;
        while (model_count > 0 && waited < DRAIN_LIMIT) begin
            oldest = model_q[0];
            wb     = '0;
            if (!oldest.payload.a_ready) begin
                wb[oldest.payload.a_pr[BANK_W-1:0]] = {1'b1, oldest.payload.a_pr[PR_W-1:BANK_W]};
            end
            if (!oldest.payload.b_ready) begin
                wb[oldest.payload.b_pr[BANK_W-1:0]] = {1'b1, oldest.payload.b_pr[PR_W-1:BANK_W]};
            end
            run_cycle('0, 1'b1, 1'b1, wb, 1'b0, '0);
            waited++;
        end
        if (model_count > 0) begin
            $display("queue did not drain within %0d cycles", DRAIN_LIMIT);
        end
        else begin
            run_cycle('0, 1'b1, 1'b1, '0, 1'b0, '0);
        end

        assert_errors = int'(i_dut.i_assert.issue_fail_count + i_dut.i_assert.ack_fail_count
                             + i_dut.i_assert.reset_fail_count);
        $display("errors: %0d check, %0d assertion", error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0 && model_count == 0) begin
            $display("TEST RESULT: PASS");
        end
        else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
